//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0 --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps
TOP        = tb_fetch
FILELIST   = tb.f
OBJ_DIR    = obj_dir
PASS_MSG   = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass message appears in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- common/fetch_pkg.sv
/*
 * Fetch front end package: widths, memory bus commands,
 * no-op word, miss FSM encodings and the fetch address union
 */
package fetch_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int ADDR_W      = 32;
  localparam int INST_W      = 32;
  localparam int LINE_W      = 64;   // One memory word, two instructions
  localparam int IDX_W       = 7;
  localparam int TAG_W       = 22;   // ADDR_W - IDX_W - 3 offset bits
  localparam int CACHE_LINES = 128;
  localparam int MEM_TAG_W   = 4;

  ////////////////////////////////////////
  // Memory bus
  ////////////////////////////////////////
  localparam logic [1:0] BUS_NONE = 2'h0;
  localparam logic [1:0] BUS_LOAD = 2'h1;

  // Alpha bis r31,r31,r31
  localparam logic [INST_W-1:0] NOOP_INST = 32'h47ff_041f;

  // Miss controller states
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_REQ  = 2'd1;   // Waiting for a non-zero response
  localparam logic [1:0] ST_WAIT = 2'd2;   // Waiting for the matching data tag

  ////////////////////////////////////////
  // Fetch address, raw or split
  ////////////////////////////////////////
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0] tag;
      logic [IDX_W-1:0] idx;
      logic             word_sel;   // Upper or lower instruction of the line
      logic [1:0]       byte_off;
    } fields;
  } fetch_addr_u;

endpackage

//--- hdl/fetch_top.sv
/*
 * Fetch front end top: fetch stage, instruction cache arrays
 * and miss controller on the tagged memory bus
 */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 stall,
  input  logic                 redirect_valid,
  input  logic [ADDR_W-1:0]    redirect_pc,
  input  logic [MEM_TAG_W-1:0] mem2proc_response,
  input  logic [MEM_TAG_W-1:0] mem2proc_tag,
  input  logic [LINE_W-1:0]    mem2proc_data,
  output logic [1:0]           proc2mem_command,
  output logic [ADDR_W-1:0]    proc2mem_addr,
  output logic [ADDR_W-1:0]    if_id_npc,
  output logic [INST_W-1:0]    if_id_ir,
  output logic                 if_id_valid
);

  fetch_addr_u       fetch_addr;   // Current PC
  logic              hit;
  logic [LINE_W-1:0] line_data;
  logic              wr_en;        // Fill strobe from the controller
  fetch_addr_u       wr_addr;

  ////////////////////////////////////////
  // Fetch stage
  ////////////////////////////////////////
  if_stage u_if_stage (
    .clock          (clock),
    .reset          (reset),
    .stall          (stall),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .hit            (hit),
    .line_data      (line_data),
    .fetch_addr     (fetch_addr),
    .if_id_npc      (if_id_npc),
    .if_id_ir       (if_id_ir),
    .if_id_valid    (if_id_valid)
  );

  ////////////////////////////////////////
  // Instruction cache
  ////////////////////////////////////////
  icache_mem u_icache_mem (
    .clock      (clock),
    .reset      (reset),
    .fetch_addr (fetch_addr),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (mem2proc_data),   // Line straight from the bus
    .hit        (hit),
    .line_data  (line_data)
  );

  icache_ctrl u_icache_ctrl (
    .clock             (clock),
    .reset             (reset),
    .fetch_addr        (fetch_addr),
    .hit               (hit),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .wr_en             (wr_en),
    .wr_addr           (wr_addr)
  );

endmodule

//--- hdl/if_stage.sv
/*
 * Fetch stage: program counter with stall and redirect,
 * instruction half select and the IF/ID register
 */
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic              stall,
  input  logic              redirect_valid,
  input  logic [ADDR_W-1:0] redirect_pc,
  input  logic              hit,
  input  logic [LINE_W-1:0] line_data,
  output fetch_addr_u       fetch_addr,
  output logic [ADDR_W-1:0] if_id_npc,
  output logic [INST_W-1:0] if_id_ir,
  output logic              if_id_valid
);

  fetch_addr_u       pc;
  logic [ADDR_W-1:0] pc_plus4;
  logic [INST_W-1:0] fetch_inst;
  logic              advance;

  assign fetch_addr = pc;
  assign pc_plus4   = pc.raw + ADDR_W'(4);
  assign advance    = hit && !stall;   // Instruction leaves this cycle

  // Word select picks one of the two instructions in the line
  assign fetch_inst = pc.fields.word_sel ? line_data[LINE_W-1:INST_W]
                                         : line_data[INST_W-1:0];

  ////////////////////////////////////////
  // Program counter
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      pc.raw <= '0;
    end else if (redirect_valid) begin
      pc.raw <= redirect_pc;           // Wins over stall
    end else if (advance) begin
      pc.raw <= pc_plus4;
    end
    // Otherwise hold on stall or miss
  end

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      if_id_npc   <= '0;
      if_id_ir    <= NOOP_INST;
      if_id_valid <= 1'b0;
    end else if (redirect_valid) begin
      if_id_valid <= 1'b0;             // Squash whatever was fetched
    end else if (!stall) begin
      if_id_valid <= hit;              // Bubble on a miss
      if (advance) begin
        if_id_npc <= pc_plus4;
        if_id_ir  <= fetch_inst;
      end
    end
  end

endmodule

//--- icache/icache_ctrl.sv
/*
 * Instruction cache miss controller: issues line loads on the
 * tagged memory bus and writes the returning line into the cache
 */
`timescale 1ns/1ps

module icache_ctrl import fetch_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  fetch_addr_u          fetch_addr,
  input  logic                 hit,
  input  logic [MEM_TAG_W-1:0] mem2proc_response,
  input  logic [MEM_TAG_W-1:0] mem2proc_tag,
  output logic [1:0]           proc2mem_command,
  output logic [ADDR_W-1:0]    proc2mem_addr,
  output logic                 wr_en,
  output fetch_addr_u          wr_addr
);

  logic [1:0]           state;
  logic [1:0]           next_state;
  logic [MEM_TAG_W-1:0] pend_tag;      // Tag handed out at acceptance
  fetch_addr_u          line_addr;     // Line being loaded
  logic                 accepted;
  logic                 tag_match;

  assign accepted  = (state == ST_REQ) && (mem2proc_response != '0);
  assign tag_match = (state == ST_WAIT) && (mem2proc_tag == pend_tag);

  ////////////////////////////////////////
  // Miss FSM
  ////////////////////////////////////////
  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE: begin
        if (!hit) begin
          next_state = ST_REQ;         // Request goes out next cycle
        end
      end
      ST_REQ: begin
        if (accepted) begin
          next_state = ST_WAIT;
        end
      end
      ST_WAIT: begin
        // Completes even if the PC has moved on after a redirect
        if (tag_match) begin
          next_state = ST_IDLE;
        end
      end
      default: begin
        next_state = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= ST_IDLE;
      pend_tag <= '0;
    end else begin
      state <= next_state;
      if (accepted) begin
        pend_tag <= mem2proc_response;
      end
    end
  end

  // Line address latched with the miss, offset bits cleared
  always_ff @(posedge clock) begin
    if (state == ST_IDLE && !hit) begin
      line_addr.raw <= {fetch_addr.raw[ADDR_W-1:3], 3'b000};
    end
  end

  ////////////////////////////////////////
  // Bus and fill outputs
  ////////////////////////////////////////
  // Held steady through back-pressure, drops once accepted
  assign proc2mem_command = (state == ST_REQ) ? BUS_LOAD : BUS_NONE;
  assign proc2mem_addr    = line_addr.raw;

  // Fill written on the edge of the matching tag cycle
  assign wr_en   = tag_match;
  assign wr_addr = line_addr;

endmodule

//--- icache/icache_mem.sv
/*
 * Instruction cache arrays: 128 direct-mapped lines of 64 bits
 * with tag and valid, combinational read, single write port
 */
`timescale 1ns/1ps

module icache_mem import fetch_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  fetch_addr_u       fetch_addr,
  input  logic              wr_en,
  input  fetch_addr_u       wr_addr,
  input  logic [LINE_W-1:0] wr_data,
  output logic              hit,
  output logic [LINE_W-1:0] line_data
);

  logic [TAG_W-1:0]       tag_mem  [CACHE_LINES];
  logic [LINE_W-1:0]      data_mem [CACHE_LINES];
  logic [CACHE_LINES-1:0] valid;

  logic [IDX_W-1:0]       rd_idx;
  logic [IDX_W-1:0]       wr_idx;

  assign rd_idx = fetch_addr.fields.idx;
  assign wr_idx = wr_addr.fields.idx;

  ////////////////////////////////////////
  // Valid bits
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;                      // Whole cache empty
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Tag and data arrays
  ////////////////////////////////////////
  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_mem[wr_idx]  <= wr_addr.fields.tag;
      data_mem[wr_idx] <= wr_data;     // Fill replaces the old line
    end
  end

  // Lookup in the same cycle as the PC
  assign hit       = valid[rd_idx] && (tag_mem[rd_idx] == fetch_addr.fields.tag);
  assign line_data = data_mem[rd_idx];

endmodule

//--- tb.f
common/fetch_pkg.sv
icache/icache_mem.sv
icache/icache_ctrl.sv
hdl/if_stage.sv
hdl/fetch_top.sv
tests/fetch_assertions.sv
tests/tb_fetch.sv

//--- tests/fetch_assertions.sv
/*
 * Bound checks on the tagged memory handshake and the reset state
 */
`timescale 1ns/1ps

module fetch_assertions import fetch_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input logic [1:0]           proc2mem_command,
  input logic [ADDR_W-1:0]    proc2mem_addr,
  input logic [MEM_TAG_W-1:0] mem2proc_response,
  input logic [MEM_TAG_W-1:0] mem2proc_tag,
  input logic                 if_id_valid
);

  logic                 load_busy;     // One load accepted and not yet returned
  logic [MEM_TAG_W-1:0] load_tag;
  logic                 held_err  = 1'b0;
  logic                 busy_err  = 1'b0;
  logic                 reset_err = 1'b0;
  logic                 assert_failed;

  assign assert_failed = held_err | busy_err | reset_err;

  always_ff @(posedge clock) begin
    if (reset) begin
      load_busy <= 1'b0;
      load_tag  <= '0;
    end else if (proc2mem_command == BUS_LOAD && mem2proc_response != '0) begin
      load_busy <= 1'b1;
      load_tag  <= mem2proc_response;
    end else if (load_busy && mem2proc_tag == load_tag) begin
      load_busy <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////
  // Zero response holds command and address
  cmd_held: assert property (@(posedge clock) disable iff (reset)
    (proc2mem_command == BUS_LOAD && mem2proc_response == '0)
      |=> (proc2mem_command == BUS_LOAD && $stable(proc2mem_addr)))
  else begin
    $error("load command or address changed under back-pressure");
    held_err = 1'b1;
  end

  no_second_load: assert property (@(posedge clock) disable iff (reset)
    load_busy |-> (proc2mem_command != BUS_LOAD))
  else begin
    $error("new load issued while one is outstanding");
    busy_err = 1'b1;
  end

  // First cycle after reset
  reset_state: assert property (@(posedge clock)
    $fell(reset) |-> (proc2mem_command == BUS_NONE && !if_id_valid))
  else begin
    $error("bus command or IF/ID valid wrong after reset");
    reset_err = 1'b1;
  end

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
  .clock             (clock),
  .reset             (reset),
  .proc2mem_command  (proc2mem_command),
  .proc2mem_addr     (proc2mem_addr),
  .mem2proc_response (mem2proc_response),
  .mem2proc_tag      (mem2proc_tag),
  .if_id_valid       (if_id_valid)
);

//--- tests/tb_fetch.sv
/*
 * Fetch front end testbench: clock and reset, tagged memory model,
 * fetch and cache models, random stall and redirect
 */
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

  localparam int NUM_INST       = 2000;
  localparam int TIMEOUT_CYCLES = NUM_INST * 12;
  localparam int MEM_WORDS      = 256;        // 2 KB of 64-bit words

  logic                 clock;
  logic                 reset;
  logic                 stall;
  logic                 redirect_valid;
  logic [ADDR_W-1:0]    redirect_pc;
  logic [MEM_TAG_W-1:0] mem2proc_response;
  logic [MEM_TAG_W-1:0] mem2proc_tag;
  logic [LINE_W-1:0]    mem2proc_data;
  logic [1:0]           proc2mem_command;
  logic [ADDR_W-1:0]    proc2mem_addr;
  logic [ADDR_W-1:0]    if_id_npc;
  logic [INST_W-1:0]    if_id_ir;
  logic                 if_id_valid;

  integer seed;
  int     cycle_count;
  int     inst_count;                         // Instructions accepted so far

  // Memory model
  logic [LINE_W-1:0]    mem_image [MEM_WORDS];
  logic [MEM_TAG_W-1:0] offer_tag;            // Tag given with the next acceptance
  logic                 load_busy;
  logic [MEM_TAG_W-1:0] load_tag;
  logic [ADDR_W-1:0]    load_addr;
  int                   load_delay;

  // Fetch and cache models
  logic [ADDR_W-1:0]      model_pc;
  logic [TAG_W-1:0]       model_tag [CACHE_LINES];
  logic [CACHE_LINES-1:0] model_valid;

  // Inputs and outputs of the previous cycle
  logic                 last_stall;
  logic                 last_redirect;
  logic [ADDR_W-1:0]    last_redirect_pc;
  logic [ADDR_W-1:0]    last_npc;
  logic [INST_W-1:0]    last_ir;
  logic                 last_valid;

  fetch_top u_fetch_top (
    .clock             (clock),
    .reset             (reset),
    .stall             (stall),
    .redirect_valid    (redirect_valid),
    .redirect_pc       (redirect_pc),
    .mem2proc_response (mem2proc_response),
    .mem2proc_tag      (mem2proc_tag),
    .mem2proc_data     (mem2proc_data),
    .proc2mem_command  (proc2mem_command),
    .proc2mem_addr     (proc2mem_addr),
    .if_id_npc         (if_id_npc),
    .if_id_ir          (if_id_ir),
    .if_id_valid       (if_id_valid)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  // Instruction at a byte address, upper half when bit 2 is set
  function automatic logic [INST_W-1:0] mem_inst(input logic [ADDR_W-1:0] addr);
    logic [LINE_W-1:0] word;
    word = mem_image[addr[10:3]];             // Image aliases above 2 KB
    return addr[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic check_eq(input string name, input logic [63:0] actual,
                          input logic [63:0] expected);
    if (actual !== expected) begin
      $display("error: %s = %h, expected %h", name, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic record_cycle();
    last_stall       = stall;
    last_redirect    = redirect_valid;
    last_redirect_pc = redirect_pc;
    last_npc         = if_id_npc;
    last_ir          = if_id_ir;
    last_valid       = if_id_valid;
  endtask

  // IF/ID outputs of this cycle against the inputs of the cycle before
  task automatic check_fetch();
    if (last_redirect) begin
      check_eq("if_id_valid", 64'(if_id_valid), 64'd0);
      model_pc = last_redirect_pc;            // Fetch restarts at the target
    end else if (last_stall) begin
      check_eq("if_id_npc", 64'(if_id_npc), 64'(last_npc));
      check_eq("if_id_ir", 64'(if_id_ir), 64'(last_ir));
      check_eq("if_id_valid", 64'(if_id_valid), 64'(last_valid));
    end else if (if_id_valid) begin
      if (inst_count == 0) begin
        check_eq("if_id_npc", 64'(if_id_npc), 64'd4);
        check_eq("if_id_ir", 64'(if_id_ir), 64'(mem_image[0][31:0]));
      end
      check_eq("if_id_npc", 64'(if_id_npc), 64'(model_pc + 32'd4));
      check_eq("if_id_ir", 64'(if_id_ir), 64'(mem_inst(model_pc)));
      model_pc = model_pc + 32'd4;
      inst_count++;
    end
    record_cycle();
  endtask

  ////////////////////////////////////////
  // Memory side
  ////////////////////////////////////////
  task automatic track_memory();
    logic [IDX_W-1:0] idx;
    logic             present;
    idx = proc2mem_addr[9:3];
    if (proc2mem_command == BUS_LOAD && mem2proc_response != '0) begin
      present = model_valid[idx] && (model_tag[idx] == proc2mem_addr[31:10]);
      check_eq("load_outstanding", 64'(load_busy), 64'd0);
      check_eq("proc2mem_addr[2:0]", 64'(proc2mem_addr[2:0]), 64'd0);
      check_eq("line_present", 64'(present), 64'd0);
      load_busy  = 1'b1;
      load_tag   = mem2proc_response;
      load_addr  = proc2mem_addr;
      load_delay = 1 + ({$random(seed)} % 6);
      offer_tag  = (offer_tag == 4'd15) ? 4'd1 : offer_tag + 4'd1;
    end
    if (load_busy && mem2proc_tag == load_tag) begin
      model_valid[load_addr[9:3]] = 1'b1;     // Evicts the old line at this index
      model_tag[load_addr[9:3]]   = load_addr[31:10];
      load_busy                   = 1'b0;
    end
  endtask

  task automatic drive_inputs();
    logic [MEM_TAG_W-1:0] ret_tag;
    logic [LINE_W-1:0]    ret_data;
    ret_tag  = '0;
    ret_data = {$random(seed), $random(seed)};   // Junk when nothing returns
    if (load_busy && load_delay > 0) begin
      load_delay--;
      if (load_delay == 0) begin
        ret_tag  = load_tag;
        ret_data = mem_image[load_addr[10:3]];
      end
    end
    mem2proc_tag      <= ret_tag;
    mem2proc_data     <= ret_data;
    mem2proc_response <= ($random(seed) & 1) ? offer_tag : '0;   // Accept half the time
    stall             <= ({$random(seed)} % 100) < 20;
    // No redirect before the first instruction
    if (inst_count > 0 && ({$random(seed)} % 100) < 3) begin
      redirect_valid <= 1'b1;
      redirect_pc    <= ({$random(seed)} % 512) * 4;
    end else begin
      redirect_valid <= 1'b0;
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    seed              = 65480;
    reset             <= 1'b1;
    stall             <= 1'b0;
    redirect_valid    <= 1'b0;
    redirect_pc       <= '0;
    mem2proc_response <= '0;
    mem2proc_tag      <= '0;
    mem2proc_data     <= '0;
    cycle_count       = 0;
    inst_count        = 0;
    offer_tag         = 4'd1;
    load_busy         = 1'b0;
    load_tag          = '0;
    load_addr         = '0;
    load_delay        = 0;
    model_pc          = '0;
    model_valid       = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_image[i] = {$random(seed), $random(seed)};
    end
    for (int i = 0; i < CACHE_LINES; i++) begin
      model_tag[i] = '0;
    end

    repeat (16) @(posedge clock);
    reset <= 1'b0;

    // First cycle out of reset
    @(posedge clock);
    check_eq("if_id_valid", 64'(if_id_valid), 64'd0);
    check_eq("if_id_ir", 64'(if_id_ir), 64'(NOOP_INST));
    check_eq("proc2mem_command", 64'(proc2mem_command), 64'(BUS_NONE));
    record_cycle();
    drive_inputs();

    while (inst_count < NUM_INST && cycle_count < TIMEOUT_CYCLES &&
           !u_fetch_top.u_fetch_assertions.assert_failed) begin
      @(posedge clock);
      cycle_count++;
      check_fetch();
      track_memory();
      drive_inputs();
    end

    // Assertion results of the last edge
    @(negedge clock);

    if (u_fetch_top.u_fetch_assertions.assert_failed) begin
      $display("a bound assertion on the memory handshake or reset state failed");
      $display("Test failed");
      $fatal(1);
    end else if (inst_count < NUM_INST) begin
      $display("timeout: only %0d of %0d instructions after %0d cycles",
               inst_count, NUM_INST, cycle_count);
      $display("Test failed");
      $fatal(1);
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule
